/* include/mau_settings.svh */
`ifndef MAU_SETTINGS_SVH
`define MAU_SETTINGS_SVH

// data path and address width of the core.
`define MAU_XLEN 64

// depth of the on-chip data RAM in 64-bit words.
// the depth must stay a power of two because the region check relies on it.
`define MAU_RAM_WORDS 512

// first byte address of the data RAM.
`define MAU_RAM_BASE 64'h0000_0000_8000_0000

// ####################
// CLINT register map.
// ####################

// software interrupt pending bit.
`define MAU_CLINT_MSIP_ADDR 64'h0000_0000_0200_0000

// timer compare value.
`define MAU_CLINT_MTIMECMP_ADDR 64'h0000_0000_0200_4000

// free-running timer.
`define MAU_CLINT_MTIME_ADDR 64'h0000_0000_0200_BFF8

`endif

/* src/mau_isa_pkg.sv */
`default_nettype none

package mau_isa_pkg;

	// load kinds, encoded exactly as the funct3 field of a load.
	typedef enum logic [2:0] {
		LB        = 3'b000,
		LH        = 3'b001,
		LW        = 3'b010,
		LD        = 3'b011,
		LBU       = 3'b100,
		LHU       = 3'b101,
		LWU       = 3'b110,
		LOAD_NONE = 3'b111
	} load_op_e;

	// store kinds, encoded as the funct3 field of a store.
	// any funct3 with the top bit set is not a valid store.
	typedef enum logic [2:0] {
		SB         = 3'b000,
		SH         = 3'b001,
		SW         = 3'b010,
		SD         = 3'b011,
		STORE_NONE = 3'b100
	} store_op_e;

endpackage

`default_nettype wire

/* src/mau_mem_pkg.sv */
`default_nettype none

package mau_mem_pkg;

	// target of a memory access.
	typedef enum logic [1:0] {
		REGION_RAM   = 2'd0,
		REGION_CLINT = 2'd1,
		REGION_NONE  = 2'd2
	} region_e;

	// register inside the CLINT that an access hits.
	typedef enum logic [1:0] {
		CLINT_MSIP     = 2'd0,
		CLINT_MTIMECMP = 2'd1,
		CLINT_MTIME    = 2'd2,
		CLINT_NONE     = 2'd3
	} clint_reg_e;

endpackage

`default_nettype wire

/* src/mau_req_if.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mau_settings.svh"

interface mau_req_if import mau_isa_pkg::*, mau_mem_pkg::*; ();

	localparam int RAM_AW = $clog2(`MAU_RAM_WORDS);

	logic                 rd;
	logic                 wr;
	load_op_e             load_op;
	region_e              region;
	clint_reg_e           clint_sel;
	logic [RAM_AW-1:0]    word_index;
	logic [2:0]           byte_offset;
	// store data is already moved to its byte lanes.
	logic [`MAU_XLEN-1:0] wdata;
	logic [7:0]           wmask;

	modport src (output rd, wr, load_op, region, clint_sel, word_index, byte_offset, wdata, wmask);
	modport dst (input rd, wr, load_op, region, clint_sel, word_index, byte_offset, wdata, wmask);

endinterface

`default_nettype wire

/* src/mau_rsp_if.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mau_settings.svh"

interface mau_rsp_if import mau_isa_pkg::*; ();

	logic                 rd;
	load_op_e             load_op;
	logic [2:0]           byte_offset;
	// the full 64-bit word as read, before any lane selection.
	logic [`MAU_XLEN-1:0] rdata;

	modport src (output rd, load_op, byte_offset, rdata);
	modport dst (input rd, load_op, byte_offset, rdata);

endinterface

`default_nettype wire

/* src/mau_req_decode.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mau_settings.svh"

module mau_req_decode import mau_isa_pkg::*, mau_mem_pkg::*; (
	input  wire                 clk,
	input  wire                 arst_n,
	input  wire                 mem_r_en,
	input  wire                 mem_w_en,
	input  wire [2:0]           funct3,
	input  wire [`MAU_XLEN-1:0] mem_addr,
	input  wire [`MAU_XLEN-1:0] mem_w_data,
	mau_req_if.src              req
);

	localparam int RAM_AW = $clog2(`MAU_RAM_WORDS);
	localparam logic [`MAU_XLEN-1:0] MSIP_A     = `MAU_CLINT_MSIP_ADDR;
	localparam logic [`MAU_XLEN-1:0] MTIMECMP_A = `MAU_CLINT_MTIMECMP_ADDR;
	localparam logic [`MAU_XLEN-1:0] MTIME_A    = `MAU_CLINT_MTIME_ADDR;

	logic [`MAU_XLEN-1:0] ram_off;
	logic [2:0]           byte_off;
	store_op_e            store_op;
	logic [7:0]           base_mask;
	region_e              region;
	clint_reg_e           clint_sel;

	assign byte_off = mem_addr[2:0];
	assign ram_off  = mem_addr - `MAU_RAM_BASE;
	assign store_op = funct3[2] ? STORE_NONE : store_op_e'(funct3);

	// ####################
	// address decode.
	// ####################

	// CLINT registers match on the whole 8-byte word, so the byte offset still applies.
	always_comb begin
		clint_sel = CLINT_NONE;
		if (ram_off[`MAU_XLEN-1:RAM_AW+3] == '0) begin
			region = REGION_RAM;
		end else if (mem_addr[`MAU_XLEN-1:3] == MSIP_A[`MAU_XLEN-1:3]) begin
			region    = REGION_CLINT;
			clint_sel = CLINT_MSIP;
		end else if (mem_addr[`MAU_XLEN-1:3] == MTIMECMP_A[`MAU_XLEN-1:3]) begin
			region    = REGION_CLINT;
			clint_sel = CLINT_MTIMECMP;
		end else if (mem_addr[`MAU_XLEN-1:3] == MTIME_A[`MAU_XLEN-1:3]) begin
			region    = REGION_CLINT;
			clint_sel = CLINT_MTIME;
		end else begin
			region = REGION_NONE;
		end
	end

	// unshifted byte mask for each store size.
	always_comb begin
		case (store_op)
			SB:      base_mask = 8'b0000_0001;
			SH:      base_mask = 8'b0000_0011;
			SW:      base_mask = 8'b0000_1111;
			SD:      base_mask = 8'b1111_1111;
			default: base_mask = 8'b0000_0000;
		endcase
	end

	// ####################
	// request register.
	// ####################

	// a store wins when both strobes are high.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			req.rd <= 1'b0;
			req.wr <= 1'b0;
		end else begin
			req.rd <= mem_r_en & ~mem_w_en;
			req.wr <= mem_w_en;
		end
	end

	// mask bits shifted beyond byte 7 fall off the 8-bit register.
	always_ff @(posedge clk) begin
		if (mem_r_en | mem_w_en) begin
			req.load_op     <= load_op_e'(funct3);
			req.region      <= region;
			req.clint_sel   <= clint_sel;
			req.word_index  <= ram_off[RAM_AW+2:3];
			req.byte_offset <= byte_off;
			req.wdata       <= mem_w_data << {byte_off, 3'b000};
			req.wmask       <= base_mask << byte_off;
		end
	end

endmodule

`default_nettype wire

/* src/mau_clint.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mau_settings.svh"

module mau_clint import mau_mem_pkg::*; (
	input  wire                  clk,
	input  wire                  arst_n,
	input  wire                  wr_en,
	input  wire clint_reg_e      sel,
	input  wire [`MAU_XLEN-1:0]  wdata,
	input  wire [7:0]            wmask,
	output logic [`MAU_XLEN-1:0] mtime,
	output logic [`MAU_XLEN-1:0] mtimecmp,
	output logic                 msip,
	output logic                 mtip
);

	logic mtime_wr;
	logic mtimecmp_wr;
	logic msip_wr;

	// replaces the bytes of old_val whose mask bit is set.
	function automatic logic [`MAU_XLEN-1:0] merge_bytes(
		input logic [`MAU_XLEN-1:0] old_val,
		input logic [`MAU_XLEN-1:0] new_val,
		input logic [7:0]           mask
	);
		logic [`MAU_XLEN-1:0] res;
		res = old_val;
		for (int i = 0; i < 8; i++) begin
			if (mask[i]) begin
				res[i*8 +: 8] = new_val[i*8 +: 8];
			end
		end
		return res;
	endfunction

	// a write with an empty mask does not count as a write.
	assign mtime_wr    = wr_en && (sel == CLINT_MTIME) && (wmask != 8'h00);
	assign mtimecmp_wr = wr_en && (sel == CLINT_MTIMECMP) && (wmask != 8'h00);
	assign msip_wr     = wr_en && (sel == CLINT_MSIP) && wmask[0];

	// mtime keeps counting on every edge it is not written.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mtime    <= '0;
			mtimecmp <= '1;
			msip     <= 1'b0;
			mtip     <= 1'b0;
		end else begin
			mtime <= mtime_wr ? merge_bytes(mtime, wdata, wmask) : mtime + 1'b1;
			if (mtimecmp_wr) begin
				mtimecmp <= merge_bytes(mtimecmp, wdata, wmask);
			end
			if (msip_wr) begin
				msip <= wdata[0];
			end
			mtip <= (mtime >= mtimecmp);
		end
	end

endmodule

`default_nettype wire

/* src/mau_mem_stage.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mau_settings.svh"

module mau_mem_stage import mau_mem_pkg::*; (
	input  wire    clk,
	input  wire    arst_n,
	mau_req_if.dst req,
	mau_rsp_if.src rsp,
	output logic   msip,
	output logic   mtip
);

	logic [`MAU_XLEN-1:0] ram [`MAU_RAM_WORDS];

	logic [`MAU_XLEN-1:0] mtime;
	logic [`MAU_XLEN-1:0] mtimecmp;
	logic [`MAU_XLEN-1:0] rdata_d;
	logic                 ram_we;
	logic                 clint_we;

	assign ram_we   = req.wr && (req.region == REGION_RAM);
	assign clint_we = req.wr && (req.region == REGION_CLINT);

	mau_clint u_clint (
		.clk      (clk),
		.arst_n   (arst_n),
		.wr_en    (clint_we),
		.sel      (req.clint_sel),
		.wdata    (req.wdata),
		.wmask    (req.wmask),
		.mtime    (mtime),
		.mtimecmp (mtimecmp),
		.msip     (msip),
		.mtip     (mtip)
	);

	// ####################
	// data RAM.
	// ####################

	// byte-enable write, one lane per mask bit.
	always_ff @(posedge clk) begin
		if (ram_we) begin
			for (int i = 0; i < 8; i++) begin
				if (req.wmask[i]) begin
					ram[req.word_index][i*8 +: 8] <= req.wdata[i*8 +: 8];
				end
			end
		end
	end

	// read data source; unmapped addresses read as zero.
	always_comb begin
		case (req.region)
			REGION_RAM: rdata_d = ram[req.word_index];
			REGION_CLINT: begin
				case (req.clint_sel)
					CLINT_MSIP:     rdata_d = {{(`MAU_XLEN-1){1'b0}}, msip};
					CLINT_MTIMECMP: rdata_d = mtimecmp;
					CLINT_MTIME:    rdata_d = mtime;
					default:        rdata_d = '0;
				endcase
			end
			default: rdata_d = '0;
		endcase
	end

	// ####################
	// response register.
	// ####################

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rsp.rd <= 1'b0;
		end else begin
			rsp.rd <= req.rd;
		end
	end

	always_ff @(posedge clk) begin
		if (req.rd) begin
			rsp.rdata       <= rdata_d;
			rsp.load_op     <= req.load_op;
			rsp.byte_offset <= req.byte_offset;
		end
	end

endmodule

`default_nettype wire

/* src/mau_load_align.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mau_settings.svh"

module mau_load_align import mau_isa_pkg::*; (
	input  wire                  clk,
	input  wire                  arst_n,
	mau_rsp_if.dst               rsp,
	output logic [`MAU_XLEN-1:0] mem_r_data,
	output logic                 load_valid
);

	logic [`MAU_XLEN-1:0] shifted;
	logic [`MAU_XLEN-1:0] result;
	logic                 fits;

	// bring the addressed byte down to lane 0.
	assign shifted = rsp.rdata >> {rsp.byte_offset, 3'b000};

	// the window has to end at or before byte 7 of the word.
	always_comb begin
		case (rsp.load_op[1:0])
			2'b00:   fits = 1'b1;
			2'b01:   fits = (rsp.byte_offset <= 3'd6);
			2'b10:   fits = (rsp.byte_offset <= 3'd4);
			default: fits = (rsp.byte_offset == 3'd0);
		endcase
	end

	always_comb begin
		case (rsp.load_op)
			LB:      result = {{(`MAU_XLEN-8){shifted[7]}}, shifted[7:0]};
			LH:      result = {{(`MAU_XLEN-16){shifted[15]}}, shifted[15:0]};
			LW:      result = {{(`MAU_XLEN-32){shifted[31]}}, shifted[31:0]};
			LD:      result = shifted;
			LBU:     result = {{(`MAU_XLEN-8){1'b0}}, shifted[7:0]};
			LHU:     result = {{(`MAU_XLEN-16){1'b0}}, shifted[15:0]};
			LWU:     result = {{(`MAU_XLEN-32){1'b0}}, shifted[31:0]};
			default: result = '0;
		endcase
		if (!fits) begin
			result = '0;
		end
	end

	// the output holds the last load result between loads.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mem_r_data <= '0;
			load_valid <= 1'b0;
		end else begin
			load_valid <= rsp.rd;
			if (rsp.rd) begin
				mem_r_data <= result;
			end
		end
	end

endmodule

`default_nettype wire

/* src/mau_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mau_settings.svh"

module mau_top (
	input  wire                  clk,
	input  wire                  arst_n,
	input  wire                  mem_r_en,
	input  wire                  mem_w_en,
	input  wire [2:0]            funct3,
	input  wire [`MAU_XLEN-1:0]  mem_addr,
	input  wire [`MAU_XLEN-1:0]  mem_w_data,
	output logic [`MAU_XLEN-1:0] mem_r_data,
	output logic                 load_valid,
	output logic                 msip,
	output logic                 mtip
);

	// stage 1 to stage 2.
	mau_req_if req_bus ();

	// stage 2 to stage 3.
	mau_rsp_if rsp_bus ();

	// ####################
	// pipeline stages.
	// ####################

	mau_req_decode u_req_decode (
		.clk        (clk),
		.arst_n     (arst_n),
		.mem_r_en   (mem_r_en),
		.mem_w_en   (mem_w_en),
		.funct3     (funct3),
		.mem_addr   (mem_addr),
		.mem_w_data (mem_w_data),
		.req        (req_bus)
	);

	// RAM and CLINT live here, so the interrupt lines come out of this stage.
	mau_mem_stage u_mem_stage (
		.clk    (clk),
		.arst_n (arst_n),
		.req    (req_bus),
		.rsp    (rsp_bus),
		.msip   (msip),
		.mtip   (mtip)
	);

	mau_load_align u_load_align (
		.clk        (clk),
		.arst_n     (arst_n),
		.rsp        (rsp_bus),
		.mem_r_data (mem_r_data),
		.load_valid (load_valid)
	);

endmodule

`default_nettype wire

/* dv/mau_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mau_settings.svh"

module mau_tb;

	localparam int XLEN          = `MAU_XLEN;
	localparam int WORDS         = `MAU_RAM_WORDS;
	localparam int N_PAIRS       = 40;
	localparam int N_ALIGN_WORDS = 4;
	localparam int N_STREAM      = 200;
	localparam int N_UNMAPPED    = 4;
	// the CLINT test includes its idle cycles in this count.
	localparam int CLINT_OPS     = 32;
	localparam int TOTAL_OPS     = WORDS + 2 * N_PAIRS + N_ALIGN_WORDS * 65 + 3 * 8 * 2
		+ N_STREAM + CLINT_OPS + 3 * N_UNMAPPED;
	localparam int WATCHDOG_NS   = TOTAL_OPS * 3 * 8 + 2000;
	localparam logic [XLEN-1:0] RAM_BASE = `MAU_RAM_BASE;
	localparam logic [XLEN-1:0] RAM_END  = `MAU_RAM_BASE + 64'(WORDS * 8);
	localparam logic [XLEN-1:0] UNMAPPED = 64'h0000_0000_1000_0000;

	logic            clk;
	logic            arst_n;
	logic            mem_r_en;
	logic            mem_w_en;
	logic [2:0]      funct3;
	logic [XLEN-1:0] mem_addr;
	logic [XLEN-1:0] mem_w_data;
	logic [XLEN-1:0] mem_r_data;
	logic            load_valid;
	logic            msip;
	logic            mtip;

	logic [XLEN-1:0] shadow [WORDS];
	logic [XLEN-1:0] exp_q [$];
	string           name_q [$];
	string           cmp_name;
	logic [XLEN-1:0] cmp_exp;
	integer          seed;

	mau_top uut (
		.clk        (clk),
		.arst_n     (arst_n),
		.mem_r_en   (mem_r_en),
		.mem_w_en   (mem_w_en),
		.funct3     (funct3),
		.mem_addr   (mem_addr),
		.mem_w_data (mem_w_data),
		.mem_r_data (mem_r_data),
		.load_valid (load_valid),
		.msip       (msip),
		.mtip       (mtip)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	// ####################
	// reference model.
	// ####################

	// load result from a whole 64-bit word, following the RV64 load rules.
	function automatic logic [XLEN-1:0] expected_load(input logic [XLEN-1:0] word,
		input logic [2:0] f3, input logic [2:0] off);
		int              nbytes;
		logic [XLEN-1:0] val;
		nbytes = 1 << f3[1:0];
		val = '0;
		// a field past the end of the word reads as zero, as does funct3 111.
		if (f3 == 3'b111 || int'(off) + nbytes > 8) begin
			return '0;
		end
		for (int i = 0; i < nbytes; i++) begin
			val[i*8 +: 8] = word[(int'(off) + i) * 8 +: 8];
		end
		if (!f3[2] && nbytes < 8 && val[nbytes*8-1]) begin
			for (int i = nbytes * 8; i < XLEN; i++) begin
				val[i] = 1'b1;
			end
		end
		return val;
	endfunction

	// bytes a store touches; anything beyond byte 7 is lost.
	function automatic logic [7:0] store_mask(input logic [2:0] f3, input int off);
		logic [7:0] m;
		int         nbytes;
		m = 8'h00;
		nbytes = 1 << f3[1:0];
		if (!f3[2]) begin
			for (int b = 0; b < 8; b++) begin
				if (b >= off && b < off + nbytes) begin
					m[b] = 1'b1;
				end
			end
		end
		return m;
	endfunction

	function automatic logic [XLEN-1:0] ram_addr(input int idx, input int off);
		return RAM_BASE + 64'(idx * 8 + off);
	endfunction

	function automatic logic [XLEN-1:0] random_word();
		return {32'($random(seed)), 32'($random(seed))};
	endfunction

	// ####################
	// stimulus tasks.
	// ####################

	task automatic apply_store(input logic [XLEN-1:0] addr, input logic [2:0] f3,
		input logic [XLEN-1:0] data);
		logic [7:0] m;
		int         idx;
		int         off;
		mem_r_en   = 1'b0;
		mem_w_en   = 1'b1;
		funct3     = f3;
		mem_addr   = addr;
		mem_w_data = data;
		if (addr >= RAM_BASE && addr < RAM_END) begin
			idx = int'((addr - RAM_BASE) >> 3);
			off = int'(addr[2:0]);
			m = store_mask(f3, off);
			for (int b = 0; b < 8; b++) begin
				if (m[b]) begin
					shadow[idx][b*8 +: 8] = data[(b - off) * 8 +: 8];
				end
			end
		end
		@(negedge clk);
	endtask

	// word is the 64-bit content the load is expected to see.
	task automatic apply_load(input string name, input logic [XLEN-1:0] addr,
		input logic [2:0] f3, input logic [XLEN-1:0] word);
		mem_r_en   = 1'b1;
		mem_w_en   = 1'b0;
		funct3     = f3;
		mem_addr   = addr;
		mem_w_data = '0;
		exp_q.push_back(expected_load(word, f3, addr[2:0]));
		name_q.push_back(name);
		@(negedge clk);
	endtask

	task automatic go_idle(input int cycles);
		mem_r_en = 1'b0;
		mem_w_en = 1'b0;
		repeat (cycles) @(negedge clk);
	endtask

	task automatic compare_values(input string name, input logic [XLEN-1:0] expected,
		input logic [XLEN-1:0] actual);
		if (actual !== expected) begin
			$display("FAILED %s expected %h actual %h", name, expected, actual);
			$display("test failed");
			$fatal(1, "value mismatch");
		end
	endtask

	// results come back in issue order, so the queue head belongs to this load_valid.
	always @(negedge clk) begin
		if (arst_n && load_valid) begin
			if (exp_q.size() == 0) begin
				$display("load_valid was seen while no load was outstanding");
				$display("test failed");
				$fatal(1, "unexpected load response");
			end else begin
				cmp_name = name_q.pop_front();
				cmp_exp  = exp_q.pop_front();
				compare_values(cmp_name, cmp_exp, mem_r_data);
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("the run did not finish in the allowed time");
		$display("test failed");
		$fatal(1, "watchdog timeout");
	end

	// ####################
	// test sequence.
	// ####################

	initial begin
		int              idx;
		int              off;
		int              k;
		logic [2:0]      f3;
		logic [XLEN-1:0] a;
		seed       = 32'hde20;
		arst_n     = 1'b0;
		mem_r_en   = 1'b0;
		mem_w_en   = 1'b0;
		funct3     = 3'b000;
		mem_addr   = '0;
		mem_w_data = '0;
		repeat (16) @(negedge clk);
		arst_n = 1'b1;
		@(negedge clk);
		compare_values("reset_mtip", 64'd0, {63'd0, mtip});
		compare_values("reset_msip", 64'd0, {63'd0, msip});

		// fill every RAM word so no load can see unknown data.
		for (int i = 0; i < WORDS; i++) begin
			a = ram_addr(i, 0);
			apply_store(a, 3'b011, {~a[31:0], a[63:32] ^ a[31:0]});
		end

		for (int i = 0; i < N_PAIRS; i++) begin
			idx = $random(seed) & (WORDS - 1);
			apply_store(ram_addr(idx, 0), 3'b011, random_word());
			apply_load("sd_ld", ram_addr(idx, 0), 3'b011, shadow[idx]);
		end

		for (int w = 0; w < N_ALIGN_WORDS; w++) begin
			idx = $random(seed) & (WORDS - 1);
			apply_store(ram_addr(idx, 0), 3'b011, random_word());
			for (int f = 0; f < 8; f++) begin
				for (int o = 0; o < 8; o++) begin
					apply_load("load_align", ram_addr(idx, o), 3'(f), shadow[idx]);
				end
			end
		end

		// SB, SH and SW at each offset, then read the whole word back.
		for (int s = 0; s < 3; s++) begin
			for (int o = 0; o < 8; o++) begin
				idx = $random(seed) & (WORDS - 1);
				apply_store(ram_addr(idx, o), 3'(s), random_word());
				apply_load("partial_store", ram_addr(idx, 0), 3'b011, shadow[idx]);
			end
		end

		// few words, so stores and loads to the same word meet in the pipeline.
		for (int n = 0; n < N_STREAM; n++) begin
			idx = $random(seed) & 15;
			off = $random(seed) & 7;
			f3 = 3'($random(seed));
			if (($random(seed) & 1) != 0) begin
				apply_store(ram_addr(idx, off), f3, random_word());
			end else begin
				apply_load("random_stream", ram_addr(idx, off), f3, shadow[idx]);
			end
		end

		apply_store(`MAU_CLINT_MSIP_ADDR, 3'b011, 64'd1);
		go_idle(3);
		compare_values("msip_set", 64'd1, {63'd0, msip});
		apply_load("msip_read", `MAU_CLINT_MSIP_ADDR, 3'b011, 64'd1);
		apply_store(`MAU_CLINT_MTIMECMP_ADDR, 3'b011, 64'd0);
		go_idle(0);
		for (k = 0; k < 4 && !mtip; k++) begin
			@(negedge clk);
		end
		compare_values("mtip_cmp_zero", 64'd1, {63'd0, mtip});
		apply_load("mtimecmp_zero_read", `MAU_CLINT_MTIMECMP_ADDR, 3'b011, 64'd0);
		// mtip is high here, so it has to drop again once mtimecmp is back at its maximum.
		apply_store(`MAU_CLINT_MTIMECMP_ADDR, 3'b011, '1);
		go_idle(4);
		compare_values("mtip_cmp_max", 64'd0, {63'd0, mtip});
		apply_load("mtimecmp_read", `MAU_CLINT_MTIMECMP_ADDR, 3'b011, '1);

		// the store address shares its low bits with RAM word idx.
		for (int u = 0; u < N_UNMAPPED; u++) begin
			idx = $random(seed) & (WORDS - 1);
			apply_load("unmapped_load", UNMAPPED + 64'(u * 8 + u), 3'(u), 64'd0);
			apply_store(RAM_BASE + 64'h1000_0000 + 64'(idx * 8), 3'b011, random_word());
			apply_load("unmapped_store", ram_addr(idx, 0), 3'b011, shadow[idx]);
		end

		go_idle(0);
		for (k = 0; k < 8 && exp_q.size() != 0; k++) begin
			@(negedge clk);
		end
		if (exp_q.size() != 0) begin
			$display("%0d loads never returned data", exp_q.size());
			$display("test failed");
			$fatal(1, "missing load responses");
		end else begin
			$display("test passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+include
src/mau_isa_pkg.sv
src/mau_mem_pkg.sv
src/mau_req_if.sv
src/mau_rsp_if.sv
src/mau_req_decode.sv
src/mau_clint.sv
src/mau_mem_stage.sv
src/mau_load_align.sv
src/mau_top.sv
dv/mau_tb.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator and run it; the exit status is the result.
cd "$(dirname "$0")" \
	&& verilator --binary --timing -f verilog.f --top-module mau_tb -o mau_sim \
	&& ./obj_dir/mau_sim \
	|| exit 1
